// ==== build.f ====
+incdir+hw
hw/core_pkg.sv
hw/alu.sv
hw/decode.sv
hw/regfile.sv
hw/execute.sv
hw/exec_core.sv
tests/exec_core_assert.sv
tests/exec_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module exec_core_tb -f build.f -o exec_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/exec_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tests/exec_core_tb.sv ====
// Testbench for the execute slice: clock, reset, instruction table, stalling consumer, watchdog
`timescale 1ns/10ps

module exec_core_tb;

    localparam int          N_TESTS = 50;
    localparam int          PERIOD  = 40;
    localparam logic [31:0] PC_BASE = 32'h0000_1000;

    // RV32I major opcodes and the alternate funct7
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    logic        sink;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        instr_ready;
    logic        result_valid;
    logic        result_ready;
    logic [4:0]  result_rd;
    logic [31:0] result_value;
    logic        result_branch;
    logic [31:0] result_target;

    logic [31:0] tbl_instr  [N_TESTS];
    logic [31:0] tbl_pc     [N_TESTS];
    logic [4:0]  tbl_rd     [N_TESTS];
    logic [31:0] tbl_value  [N_TESTS];
    logic        tbl_branch [N_TESTS];
    logic [31:0] tbl_target [N_TESTS];
    int          n_built;
    int          errors;
    logic [31:0] rand_state;

    exec_core uut (
        .sink          (sink),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .instr_ready   (instr_ready),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result_rd     (result_rd),
        .result_value  (result_value),
        .result_branch (result_branch),
        .result_target (result_target)
    );

    initial begin
        sink = 1'b0;
        forever #(PERIOD / 2) sink = ~sink;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Instruction encoders following the ISA field layout
    function automatic logic [31:0] r_type(input int rd, input int rs1, input int rs2,
                                           input logic [2:0] f3, input logic [6:0] f7);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input int rd, input int rs1, input int imm,
                                           input logic [2:0] f3, input logic [6:0] opc);
        logic [31:0] v;
        v = imm;
        return {v[11:0], 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input int imm20, input logic [6:0] opc);
        logic [31:0] v;
        v = imm20;
        return {v[19:0], 5'(rd), opc};
    endfunction

    function automatic logic [31:0] b_type(input int rs1, input int rs2, input int off,
                                           input logic [2:0] f3);
        logic [31:0] o;
        o = off;
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        logic [31:0] o;
        o = off;
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] current_pc();
        return PC_BASE + 32'(n_built) * 32'd4;
    endfunction

    task automatic store_entry(input logic [31:0] word, input int rd, input logic [31:0] value,
                               input logic branch, input logic [31:0] target);
        if (n_built < N_TESTS) begin
            tbl_instr[n_built]  = word;
            tbl_pc[n_built]     = current_pc();
            tbl_rd[n_built]     = 5'(rd);
            tbl_value[n_built]  = value;
            tbl_branch[n_built] = branch;
            tbl_target[n_built] = target;
        end
        n_built++;
    endtask

    // Straight-line instruction, falls through to pc+4
    task automatic value_case(input logic [31:0] word, input int rd, input logic [31:0] value);
        store_entry(word, rd, value, 1'b0, current_pc() + 32'd4);
    endtask

    // Branches write nothing and report pc+off only when taken
    task automatic branch_case(input logic [31:0] word, input int off, input logic taken);
        logic [31:0] target;
        target = taken ? current_pc() + 32'(off) : current_pc() + 32'd4;
        store_entry(word, 0, 32'd0, taken, target);
    endtask

    task automatic build_table();
        logic [31:0] link27;
        logic [31:0] link29;
        n_built = 0;
        value_case(i_type(1, 0, 5, 3'b000, OPC_OP_IMM), 1, 32'd5);
        value_case(i_type(2, 0, -3, 3'b000, OPC_OP_IMM), 2, 32'hFFFF_FFFD);
        value_case(u_type(3, 32'h12345, OPC_LUI), 3, 32'h1234_5000);
        value_case(u_type(4, 32'h00010, OPC_AUIPC), 4, current_pc() + 32'h0001_0000);
        // Write to x0 shows its sum but must not land
        value_case(i_type(0, 1, 7, 3'b000, OPC_OP_IMM), 0, 32'd12);
        value_case(r_type(5, 0, 1, 3'b000, 7'd0), 5, 32'd5);
        value_case(u_type(6, 32'h80000, OPC_LUI), 6, 32'h8000_0000);
        value_case(i_type(7, 0, 31, 3'b000, OPC_OP_IMM), 7, 32'd31);
        // All ten register functions with x1 = 5, x2 = -3, x6 = min int, x7 = 31
        value_case(r_type(8, 1, 2, 3'b000, 7'd0), 8, 32'd2);
        value_case(r_type(9, 1, 2, 3'b000, F7_ALT), 9, 32'd8);
        value_case(r_type(10, 2, 1, 3'b000, F7_ALT), 10, 32'hFFFF_FFF8);
        value_case(r_type(11, 1, 7, 3'b001, 7'd0), 11, 32'h8000_0000);
        value_case(r_type(12, 2, 1, 3'b010, 7'd0), 12, 32'd1);
        value_case(r_type(19, 1, 2, 3'b010, 7'd0), 19, 32'd0);
        value_case(r_type(13, 2, 1, 3'b011, 7'd0), 13, 32'd0);
        value_case(r_type(20, 1, 2, 3'b011, 7'd0), 20, 32'd1);
        value_case(r_type(14, 1, 2, 3'b100, 7'd0), 14, 32'hFFFF_FFF8);
        value_case(r_type(15, 6, 7, 3'b101, 7'd0), 15, 32'd1);
        value_case(r_type(16, 6, 7, 3'b101, F7_ALT), 16, 32'hFFFF_FFFF);
        value_case(r_type(17, 1, 6, 3'b110, 7'd0), 17, 32'h8000_0005);
        value_case(r_type(18, 2, 1, 3'b111, 7'd0), 18, 32'd5);
        value_case(i_type(21, 6, 32'h404, 3'b101, OPC_OP_IMM), 21, 32'hF800_0000);
        value_case(i_type(23, 1, -1, 3'b100, OPC_OP_IMM), 23, 32'hFFFF_FFFA);
        // Each one reads the rd of the one before
        value_case(i_type(24, 0, 1, 3'b000, OPC_OP_IMM), 24, 32'd1);
        value_case(r_type(24, 24, 24, 3'b000, 7'd0), 24, 32'd2);
        value_case(r_type(24, 24, 24, 3'b000, 7'd0), 24, 32'd4);
        value_case(i_type(24, 24, 2, 3'b001, OPC_OP_IMM), 24, 32'd16);
        value_case(r_type(25, 24, 1, 3'b000, F7_ALT), 25, 32'd11);
        value_case(r_type(25, 25, 24, 3'b000, 7'd0), 25, 32'd27);
        branch_case(b_type(1, 1, 16, 3'b000), 16, 1'b1);
        branch_case(b_type(1, 2, 16, 3'b000), 16, 1'b0);
        branch_case(b_type(1, 2, -8, 3'b001), -8, 1'b1);
        branch_case(b_type(1, 1, -8, 3'b001), -8, 1'b0);
        branch_case(b_type(2, 1, 64, 3'b100), 64, 1'b1);
        branch_case(b_type(1, 2, 64, 3'b100), 64, 1'b0);
        branch_case(b_type(1, 2, -256, 3'b101), -256, 1'b1);
        branch_case(b_type(2, 1, -256, 3'b101), -256, 1'b0);
        branch_case(b_type(1, 2, 2000, 3'b110), 2000, 1'b1);
        branch_case(b_type(2, 1, 2000, 3'b110), 2000, 1'b0);
        branch_case(b_type(2, 1, -4096, 3'b111), -4096, 1'b1);
        branch_case(b_type(1, 2, -4096, 3'b111), -4096, 1'b0);
        // Sources must be untouched by the branches
        value_case(r_type(26, 1, 2, 3'b000, 7'd0), 26, 32'd2);
        link27 = current_pc() + 32'd4;
        store_entry(j_type(27, 2048), 27, link27, 1'b1, current_pc() + 32'd2048);
        store_entry(j_type(0, -16), 0, current_pc() + 32'd4, 1'b1, current_pc() - 32'd16);
        value_case(i_type(28, 0, 32'h123, 3'b000, OPC_OP_IMM), 28, 32'h0000_0123);
        link29 = current_pc() + 32'd4;
        store_entry(i_type(29, 28, 4, 3'b000, OPC_JALR), 29, link29, 1'b1, 32'h0000_0126);
        value_case(r_type(30, 29, 0, 3'b000, 7'd0), 30, link29);
        value_case(32'h0000_000F, 0, 32'd0);
        value_case(32'h0011_2023, 0, 32'd0);
        value_case(r_type(31, 27, 0, 3'b000, 7'd0), 31, link27);
    endtask

    task automatic drive_instructions();
        for (int i = 0; i < N_TESTS; i++) begin
            instr_valid <= 1'b1;
            instr       <= tbl_instr[i];
            pc          <= tbl_pc[i];
            @(negedge sink);
            while (!instr_ready) @(negedge sink);
            @(posedge sink);
        end
        instr_valid <= 1'b0;
    endtask

    task automatic collect_results();
        int          idx;
        logic        held;
        logic [4:0]  held_rd;
        logic [31:0] held_value;
        logic        held_branch;
        logic [31:0] held_target;
        idx  = 0;
        held = 1'b0;
        while (idx < N_TESTS) begin
            @(posedge sink);
            rand_state = next_random(rand_state);
            result_ready <= (rand_state[31:24] < 8'd179);
            @(negedge sink);
            if (held) begin
                check("result_rd while stalled", 32'(held_rd), 32'(result_rd));
                check("result_value while stalled", held_value, result_value);
                check("result_branch while stalled", 32'(held_branch), 32'(result_branch));
                check("result_target while stalled", held_target, result_target);
            end
            held        = result_valid && !result_ready;
            held_rd     = result_rd;
            held_value  = result_value;
            held_branch = result_branch;
            held_target = result_target;
            if (result_valid && result_ready) begin
                check("result_rd", 32'(tbl_rd[idx]), 32'(result_rd));
                check("result_value", tbl_value[idx], result_value);
                check("result_branch", 32'(tbl_branch[idx]), 32'(result_branch));
                check("result_target", tbl_target[idx], result_target);
                idx++;
            end
        end
        @(posedge sink);
        result_ready <= 1'b1;
    endtask

    initial begin
        errors       = 0;
        rand_state   = 32'h06413829;
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= 32'd0;
        pc          <= 32'd0;
        result_ready <= 1'b0;
        build_table();
        if (n_built != N_TESTS) begin
            errors++;
            $display("Instruction table holds %0d entries instead of %0d", n_built, N_TESTS);
        end
        repeat (5) @(posedge sink);
        rst_n <= 1'b1;
        // Both stages empty once reset is released
        @(negedge sink);
        check("instr_ready after reset", 32'd1, 32'(instr_ready));
        check("result_valid after reset", 32'd0, 32'(result_valid));
        @(posedge sink);
        fork
            drive_instructions();
            collect_results();
        join
        // Nothing may come out once the table is drained
        repeat (4) @(posedge sink);
        @(negedge sink);
        check("result_valid after last result", 32'd0, 32'(result_valid));
        $display("Results checked: %0d, errors: %0d", N_TESTS, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        #(PERIOD * (N_TESTS * 20 + 50));
        $display("Timeout: not all results arrived in time, errors: %0d", errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== tests/exec_core_assert.sv ====
// Concurrent assertions on the instruction and result stream handshakes, bound to exec_core
`timescale 1ns/10ps

module exec_core_assert
    import core_pkg::*;
(
    input logic  sink,
    input logic  rst_n,
    input logic  instr_valid,
    input logic  instr_ready,
    input logic  de_valid,
    input word_t de_pc,
    input logic  result_valid,
    input logic  result_ready,
    input reg_t  result_rd,
    input word_t result_value,
    input logic  result_branch,
    input word_t result_target
);

    // Output stage stays empty while reset is applied
    a_reset_empty: assert property (@(posedge sink) !rst_n |-> !result_valid)
        else $error("result_valid high during reset");

    // A stalled result keeps valid and every field
    a_result_hold: assert property (@(posedge sink) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result_rd)
            && $stable(result_value) && $stable(result_branch) && $stable(result_target))
        else $error("result stream changed while stalled");

    // No instruction is taken in while instr_ready is low
    a_no_transfer: assert property (@(posedge sink) disable iff (!rst_n)
        instr_valid && !instr_ready |=> de_valid && $stable(de_pc))
        else $error("decode stage loaded while instr_ready was low");

endmodule

bind exec_core exec_core_assert u_assert (
    .sink          (sink),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr_ready   (instr_ready),
    .de_valid      (de_valid),
    .de_pc         (de_pc),
    .result_valid  (result_valid),
    .result_ready  (result_ready),
    .result_rd     (result_rd),
    .result_value  (result_value),
    .result_branch (result_branch),
    .result_target (result_target)
);

// ==== hw/exec_core.sv ====
// Top level of the execute slice: decode, register file and execute
`timescale 1ns/10ps

module exec_core
    import core_pkg::*;
(
    input  logic        sink,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  word_t       pc,
    output logic        instr_ready,
    output logic        result_valid,
    input  logic        result_ready,
    output reg_t        result_rd,
    output word_t       result_value,
    output logic        result_branch,
    output word_t       result_target
);

    logic    de_valid;
    logic    de_ready;
    op_t     de_op;
    alu_fn_t de_fn;
    br_t     de_br;
    reg_t    de_rd;
    reg_t    de_rs1;
    reg_t    de_rs2;
    word_t   de_imm;
    word_t   de_pc;
    logic    de_use_imm;
    word_t   rs1_data;
    word_t   rs2_data;
    logic    wb_en;
    reg_t    wb_rd;
    word_t   wb_data;

    decode u_decode (
        .sink        (sink),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr_u'(instr)),
        .pc          (pc),
        .instr_ready (instr_ready),
        .de_valid    (de_valid),
        .de_ready    (de_ready),
        .de_op       (de_op),
        .de_fn       (de_fn),
        .de_br       (de_br),
        .de_rd       (de_rd),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_imm      (de_imm),
        .de_pc       (de_pc),
        .de_use_imm  (de_use_imm)
    );

    // Read ports are addressed straight from the decode register
    regfile u_regfile (
        .sink     (sink),
        .rst_n    (rst_n),
        .rs1      (de_rs1),
        .rs2      (de_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    execute u_execute (
        .sink          (sink),
        .rst_n         (rst_n),
        .de_valid      (de_valid),
        .de_ready      (de_ready),
        .de_op         (de_op),
        .de_fn         (de_fn),
        .de_br         (de_br),
        .de_rd         (de_rd),
        .de_rs1        (de_rs1),
        .de_rs2        (de_rs2),
        .de_imm        (de_imm),
        .de_pc         (de_pc),
        .de_use_imm    (de_use_imm),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result_rd     (result_rd),
        .result_value  (result_value),
        .result_target (result_target),
        .result_branch (result_branch)
    );

endmodule

// ==== hw/execute.sv ====
// Execute stage: bypass, branch compare, jump target, ALU and result register
`timescale 1ns/10ps
`include "core_settings.svh"

module execute
    import core_pkg::*;
(
    input  logic    sink,
    input  logic    rst_n,
    input  logic    de_valid,
    output logic    de_ready,
    input  op_t     de_op,
    input  alu_fn_t de_fn,
    input  br_t     de_br,
    input  reg_t    de_rd,
    input  reg_t    de_rs1,
    input  reg_t    de_rs2,
    input  word_t   de_imm,
    input  word_t   de_pc,
    input  logic    de_use_imm,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    output logic    wb_en,
    output reg_t    wb_rd,
    output word_t   wb_data,
    output logic    result_valid,
    input  logic    result_ready,
    output reg_t    result_rd,
    output word_t   result_value,
    output word_t   result_target,
    output logic    result_branch
);

    logic  fwd_ok;
    logic  eq;
    logic  lt;
    logic  ltu;
    logic  cond;
    logic  taken;
    word_t rs1_val;
    word_t rs2_val;
    word_t op1;
    word_t op2;
    word_t alu_out;
    word_t link_pc;
    word_t jump_sum;
    word_t value;

    assign de_ready = ~result_valid | result_ready;

    // Held result not yet written back overrides the register file
    assign fwd_ok  = result_valid & (result_rd != '0);
    assign rs1_val = (fwd_ok && result_rd == de_rs1) ? result_value : rs1_data;
    assign rs2_val = (fwd_ok && result_rd == de_rs2) ? result_value : rs2_data;

    assign op1 = (de_op == AUIPC) ? de_pc : rs1_val;
    assign op2 = de_use_imm ? de_imm : rs2_val;

    alu u_alu (
        .fn  (de_fn),
        .op1 (op1),
        .op2 (op2),
        .out (alu_out)
    );

    // Comparators
    assign eq  = rs1_val == rs2_val;
    assign lt  = $signed(rs1_val) < $signed(rs2_val);
    assign ltu = rs1_val < rs2_val;

    always_comb begin
        case (de_br)
            BEQ:     cond = eq;
            BNE:     cond = ~eq;
            BLT:     cond = lt;
            BGE:     cond = ~lt;
            BLTU:    cond = ltu;
            BGEU:    cond = ~ltu;
            default: cond = 1'b0;
        endcase
    end

    assign taken = (de_op == JUMP) | (de_op == JUMPR) | ((de_op == BRANCH) & cond);

    // JALR adds to rs1, JAL and branches add to pc
    assign link_pc  = de_pc + `XLEN'd4;
    assign jump_sum = ((de_op == JUMPR) ? rs1_val : de_pc) + de_imm;

    always_comb begin
        case (de_op)
            ALU, AUIPC:   value = alu_out;
            LUI:          value = de_imm;
            JUMP, JUMPR:  value = link_pc;
            default:      value = '0;
        endcase
    end

    always_ff @(posedge sink or negedge rst_n) begin
        if (!rst_n)
            result_valid <= 1'b0;
        else if (de_ready)
            result_valid <= de_valid;
    end

    always_ff @(posedge sink) begin
        if (de_valid && de_ready) begin
            result_rd     <= de_rd;
            result_value  <= value;
            result_branch <= taken;
            result_target <= taken ? {jump_sum[`XLEN-1:1], 1'b0} : link_pc;
        end
    end

    // Write back on the edge the consumer takes the result
    assign wb_en   = result_valid & result_ready & (result_rd != '0);
    assign wb_rd   = result_rd;
    assign wb_data = result_value;

endmodule

// ==== hw/regfile.sv ====
// Integer register file, two combinational reads and one clocked write
`timescale 1ns/10ps
`include "core_settings.svh"

module regfile
    import core_pkg::*;
(
    input  logic  sink,
    input  logic  rst_n,
    input  reg_t  rs1,
    input  reg_t  rs2,
    output word_t rs1_data,
    output word_t rs2_data,
    input  logic  wb_en,
    input  reg_t  wb_rd,
    input  word_t wb_data
);

    word_t regs [`NREGS];

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 is never written since execute masks rd zero
    always_ff @(posedge sink or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

// ==== hw/decode.sv ====
// Decode stage: instruction word to control fields, register indices and immediate
`timescale 1ns/10ps
`include "core_settings.svh"

module decode
    import core_pkg::*;
(
    input  logic    sink,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  instr_u  instr,
    input  word_t   pc,
    output logic    instr_ready,
    output logic    de_valid,
    input  logic    de_ready,
    output op_t     de_op,
    output alu_fn_t de_fn,
    output br_t     de_br,
    output reg_t    de_rd,
    output reg_t    de_rs1,
    output reg_t    de_rs2,
    output word_t   de_imm,
    output word_t   de_pc,
    output logic    de_use_imm
);

    logic    accept;
    word_t   imm_i;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    op_t     d_op;
    alu_fn_t d_fn;
    br_t     d_br;
    reg_t    d_rd;
    reg_t    d_rs1;
    reg_t    d_rs2;
    word_t   d_imm;
    logic    d_use_imm;

    // Room when empty or the held item moves on this cycle
    assign instr_ready = ~de_valid | de_ready;
    assign accept      = instr_valid & instr_ready;

    // Immediates for each format, sign extended
    assign imm_i = {{(`XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_b = {{(`XLEN-13){instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm, 12'b0};
    assign imm_j = {{(`XLEN-21){instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

    always_comb begin
        // Anything unknown retires as a no-op writing x0
        d_op      = NOP;
        d_fn      = ADD;
        d_br      = BEQ;
        d_rd      = '0;
        d_rs1     = '0;
        d_rs2     = '0;
        d_imm     = '0;
        d_use_imm = 1'b0;
        case (instr.r_fmt.opcode)
            OPC_OP: begin
                d_op  = ALU;
                d_fn  = alu_fn_t'({instr.r_fmt.funct7[5], instr.r_fmt.funct3});
                d_rd  = instr.r_fmt.rd;
                d_rs1 = instr.r_fmt.rs1;
                d_rs2 = instr.r_fmt.rs2;
            end
            OPC_OP_IMM: begin
                d_op      = ALU;
                // funct7 bit only matters for SRAI, elsewhere it is immediate
                if (instr.i_fmt.funct3 == 3'b101)
                    d_fn = alu_fn_t'({instr.r_fmt.funct7[5], instr.i_fmt.funct3});
                else
                    d_fn = alu_fn_t'({1'b0, instr.i_fmt.funct3});
                d_rd      = instr.i_fmt.rd;
                d_rs1     = instr.i_fmt.rs1;
                d_imm     = imm_i;
                d_use_imm = 1'b1;
            end
            OPC_LUI: begin
                d_op  = LUI;
                d_rd  = instr.u_fmt.rd;
                d_imm = imm_u;
            end
            OPC_AUIPC: begin
                d_op      = AUIPC;
                d_rd      = instr.u_fmt.rd;
                d_imm     = imm_u;
                d_use_imm = 1'b1;
            end
            OPC_JAL: begin
                d_op  = JUMP;
                d_rd  = instr.j_fmt.rd;
                d_imm = imm_j;
            end
            OPC_JALR: begin
                d_op  = JUMPR;
                d_rd  = instr.i_fmt.rd;
                d_rs1 = instr.i_fmt.rs1;
                d_imm = imm_i;
            end
            OPC_BRANCH: begin
                d_op  = BRANCH;
                d_br  = br_t'(instr.b_fmt.funct3);
                d_rs1 = instr.b_fmt.rs1;
                d_rs2 = instr.b_fmt.rs2;
                d_imm = imm_b;
            end
            default: begin
                d_op = NOP;
            end
        endcase
    end

    always_ff @(posedge sink or negedge rst_n) begin
        if (!rst_n)
            de_valid <= 1'b0;
        else if (instr_ready)
            de_valid <= instr_valid;
    end

    always_ff @(posedge sink) begin
        if (accept) begin
            de_op      <= d_op;
            de_fn      <= d_fn;
            de_br      <= d_br;
            de_rd      <= d_rd;
            de_rs1     <= d_rs1;
            de_rs2     <= d_rs2;
            de_imm     <= d_imm;
            de_pc      <= pc;
            de_use_imm <= d_use_imm;
        end
    end

endmodule

// ==== hw/alu.sv ====
// Combinational RV32I ALU for the ten register and immediate functions
`timescale 1ns/10ps

module alu
    import core_pkg::*;
(
    input  alu_fn_t fn,
    input  word_t   op1,
    input  word_t   op2,
    output word_t   out
);

    logic [4:0] shamt;

    // Only the low five bits of the second operand shift
    assign shamt = op2[4:0];

    always_comb begin
        case (fn)
            ADD: begin
                out = op1 + op2;
            end
            SUB: begin
                out = op1 - op2;
            end
            SLL: begin
                out = op1 << shamt;
            end
            SLT: begin
                out = word_t'($signed(op1) < $signed(op2));
            end
            SLTU: begin
                out = word_t'(op1 < op2);
            end
            XOR: begin
                out = op1 ^ op2;
            end
            SRL: begin
                out = op1 >> shamt;
            end
            SRA: begin
                // Arithmetic shift keeps the sign bit
                out = word_t'($signed(op1) >>> shamt);
            end
            OR: begin
                out = op1 | op2;
            end
            AND: begin
                out = op1 & op2;
            end
            default: begin
                out = '0;
            end
        endcase
    end

endmodule

// ==== hw/core_pkg.sv ====
// Shared types: data word, register index, control enums and instruction formats
`include "core_settings.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]  word_t;
    typedef logic [`REG_W-1:0] reg_t;

    // Major opcodes handled by this slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Instruction class seen by execute
    typedef enum logic [2:0] {
        ALU,
        LUI,
        AUIPC,
        JUMP,
        JUMPR,
        BRANCH,
        NOP
    } op_t;

    // Branch conditions, values are the funct3 codes
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_t;

    // ALU functions as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_fn_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_t       rs2;
        reg_t       rs1;
        logic [2:0] funct3;
        reg_t       rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_t        rs1;
        logic [2:0]  funct3;
        reg_t        rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_t       rs2;
        reg_t       rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_t       rs2;
        reg_t       rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_t        rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_t       rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word viewed in each format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

// ==== hw/core_settings.svh ====
// Data width, register count and register index width macros
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of one data word and of the pc
`define XLEN 32

// Integer register file size
`define NREGS 32

// Bits needed to name one register
`define REG_W 5

`endif
